// ==== src.f ====
+incdir+tb
source/riscv_pkg.sv
source/lsu_pkg.sv
source/ls_decode.sv
source/local_mem_unit.sv
source/load_attr_fifo.sv
source/load_align.sv
source/load_store_unit.sv
tb/tb_load_store_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module tb_load_store_unit -Mdir obj_dir

output=$(./obj_dir/Vtb_load_store_unit)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
else
    exit 1
fi

// ==== tb/tb_tasks.svh ====
// Driver, compare and directed test tasks for the load/store unit testbench
// Included inside the testbench module; uses its signals and reference model

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// Compare tasks
task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("FAILED %s expected %h got %h", name, exp, act);
        error_count++;
    end
endtask

task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp) begin
        $display("FAILED %s expected %h got %h", name, exp, act);
        error_count++;
    end
endtask

task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
    if (act !== exp) begin
        $display("FAILED %s expected %h got %h", name, exp, act);
        error_count++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED %s expected %h got %h", name, exp, act);
        error_count++;
    end
endtask

//////////////////////////////////////////////////
// Encoding helpers
function automatic inst_t encode_load(input fn3_t f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd5, LOAD_OPCODE};
endfunction

function automatic inst_t encode_store(input fn3_t f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], STORE_OPCODE};
endfunction

// rs1 value that reaches addr with the given offset
function automatic logic [31:0] base_for(input logic [31:0] addr, input logic [11:0] imm);
    return addr - {{20{imm[11]}}, imm};
endfunction

function automatic id_t next_tag();
    tag_count = tag_count + 1'b1;
    return tag_count;
endfunction

//////////////////////////////////////////////////
// Checks the results due this cycle and then drives the next request
task automatic check_outputs();
    logic due;
    due = (exp_due.size() > 0) && (exp_due[0] == cycle_count);
    check_flag("ready", 1'b1, ready);
    check_flag("unit_needed", exp_unit, unit_needed);
    check_flag("wb_done", due, wb_done);
    if (due) begin
        check_id("wb_id", exp_id.pop_front(), wb_id);
        check_word("wb_rd", exp_data.pop_front(), wb_rd);
        void'(exp_due.pop_front());
    end
    check_flag("exc_valid", exc_pend, exc_valid);
    if (exc_pend) begin
        check_code("exc_code", exc_exp_code, exc_code);
        check_word("exc_tval", exc_exp_tval, exc_tval);
        check_id("exc_id", exc_exp_id, exc_id);
    end
    exc_pend = 1'b0;
endtask

task automatic step(input logic valid, input inst_t inst, input logic [31:0] a,
                    input logic [31:0] b, input id_t tag, input logic unit);
    @(negedge clk);
    cycle_count++;
    check_outputs();
    issue_valid = valid;
    instruction = inst;
    rs1_data = a;
    rs2_data = b;
    id = tag;
    exp_unit = unit;
endtask

task automatic issue_ls(input logic store, input fn3_t f3, input logic [31:0] base,
                        input logic [11:0] imm, input logic [31:0] data);
    logic [31:0] addr;
    logic bad;
    id_t tag;
    addr = base + {{20{imm[11]}}, imm};
    tag = next_tag();
    case (f3[1:0])
        2'b01: bad = addr[0];
        2'b10: bad = (addr[1:0] != 2'b00);
        default: bad = 1'b0;
    endcase
    step(1'b1, store ? encode_store(f3, imm) : encode_load(f3, imm), base, data, tag, 1'b1);
    if (bad) begin
        exc_pend = 1'b1;
        exc_exp_code = store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
        exc_exp_tval = addr;
        exc_exp_id = tag;
    end else if (store) begin
        model_store(f3, addr, data);
    end else begin
        exp_due.push_back(cycle_count + LATENCY);
        exp_id.push_back(tag);
        exp_data.push_back(expected_load(f3, addr));
    end
endtask

//////////////////////////////////////////////////
// Directed tests
task automatic fill_memory();
    for (int i = 0; i < 256; i++)
        issue_ls(1'b1, LS_W_FN3, i * 4, 12'h000, {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'ha5});
endtask

task automatic test_word_rw();
    logic [31:0] addrs [16];
    logic [31:0] rnd;
    logic [11:0] imm;
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        addrs[i] = {rnd[31:2], 2'b00};
        imm = {rnd[11:2], 2'b00};
        issue_ls(1'b1, LS_W_FN3, base_for(addrs[i], imm), imm, $random(seed));
    end
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        imm = {rnd[13:4], 2'b00};
        issue_ls(1'b0, LS_W_FN3, base_for(addrs[i], imm), imm, 32'h0);
    end
endtask

task automatic test_sub_word();
    logic [31:0] words [2];
    logic [31:0] base;
    words[0] = 32'h7f8001ff;
    words[1] = 32'h80ff7f01;
    for (int w = 0; w < 2; w++) begin
        base = 32'h100 + 32'(w) * 4;
        issue_ls(1'b1, LS_W_FN3, base, 12'h000, words[w]);
        for (int b = 0; b < 4; b++) begin
            issue_ls(1'b0, LS_B_FN3, base, 12'(b), 32'h0);
            issue_ls(1'b0, L_BU_FN3, base, 12'(b), 32'h0);
        end
        for (int h = 0; h < 4; h += 2) begin
            issue_ls(1'b0, LS_H_FN3, base, 12'(h), 32'h0);
            issue_ls(1'b0, L_HU_FN3, base, 12'(h), 32'h0);
        end
    end
endtask

task automatic test_partial_store();
    issue_ls(1'b1, LS_W_FN3, 32'h200, 12'h000, 32'hdeadbeef);
    for (int b = 0; b < 4; b++) begin
        issue_ls(1'b1, LS_B_FN3, 32'h200, 12'(b), $random(seed));
        issue_ls(1'b0, LS_W_FN3, 32'h200, 12'h000, 32'h0);
    end
    for (int h = 0; h < 4; h += 2) begin
        issue_ls(1'b1, LS_H_FN3, 32'h200, 12'(h), $random(seed));
        issue_ls(1'b0, LS_W_FN3, 32'h200, 12'h000, 32'h0);
    end
endtask

// Offsets are negative, so tval also covers the offset add
task automatic test_misaligned();
    issue_ls(1'b1, LS_W_FN3, 32'h300, 12'h000, 32'h0badf00d);
    for (int off = 1; off < 4; off++) begin
        issue_ls(1'b0, LS_W_FN3, 32'h320, 12'(off - 32), 32'h0);
        issue_ls(1'b1, LS_W_FN3, 32'h320, 12'(off - 32), $random(seed));
    end
    for (int off = 1; off < 4; off += 2) begin
        issue_ls(1'b0, LS_H_FN3, 32'h320, 12'(off - 32), 32'h0);
        issue_ls(1'b0, L_HU_FN3, 32'h320, 12'(off - 32), 32'h0);
        issue_ls(1'b1, LS_H_FN3, 32'h320, 12'(off - 32), $random(seed));
    end
    issue_ls(1'b0, LS_W_FN3, 32'h300, 12'h000, 32'h0);
endtask

task automatic test_back_to_back();
    logic [31:0] rnd;
    logic [11:0] imm;
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        // Odd iterations use a negative offset
        imm = {i[0], rnd[30:22], 2'b00};
        issue_ls(1'b0, LS_W_FN3, base_for({rnd[19:2], 2'b00}, imm), imm, 32'h0);
    end
endtask

// ADD, LUI and an RV64 LD encoding
task automatic test_non_ls();
    step(1'b1, 32'h002081b3, $random(seed), $random(seed), next_tag(), 1'b0);
    step(1'b1, 32'h12345137, $random(seed), $random(seed), next_tag(), 1'b0);
    step(1'b1, {12'h010, 5'd1, 3'b011, 5'd5, LOAD_OPCODE}, 32'h100, 32'h0, next_tag(), 1'b0);
endtask

`endif

// ==== tb/tb_load_store_unit.sv ====
// Testbench for the load/store unit
// Drives directed load and store sequences into the DUT on the falling
// clock edge and checks writebacks and exceptions every cycle against a
// reference memory model. Tasks and checks live in tb_tasks.svh.

`timescale 1ns/1ns
`default_nettype none

module tb_load_store_unit;
    import riscv_pkg::*;
    import lsu_pkg::*;

    localparam int LATENCY = 1;
    // Fill, word r/w, sub-word, partial store, misaligned, back-to-back, non-LS, drain
    localparam int NUM_OPS = 256 + 32 + 26 + 13 + 14 + 16 + 3 + 3;

    logic clk;
    logic rst;
    logic issue_valid;
    inst_t instruction;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    id_t id;
    logic ready;
    logic unit_needed;
    logic wb_done;
    id_t wb_id;
    logic [31:0] wb_rd;
    logic exc_valid;
    exc_code_t exc_code;
    logic [31:0] exc_tval;
    id_t exc_id;

    // Reference model and expected results
    logic [31:0] ref_mem [256];
    int exp_due [$];
    id_t exp_id [$];
    logic [31:0] exp_data [$];
    logic exc_pend;
    exc_code_t exc_exp_code;
    logic [31:0] exc_exp_tval;
    id_t exc_exp_id;
    logic exp_unit;

    int cycle_count;
    int error_count;
    integer seed;
    id_t tag_count;

    load_store_unit u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .instruction (instruction),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id          (id),
        .ready       (ready),
        .unit_needed (unit_needed),
        .wb_done     (wb_done),
        .wb_id       (wb_id),
        .wb_rd       (wb_rd),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .exc_tval    (exc_tval),
        .exc_id      (exc_id)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    `include "tb_tasks.svh"

    //////////////////////////////////////////////////
    // Reference memory model
    task automatic model_store(input fn3_t f3, input logic [31:0] addr, input logic [31:0] data);
        logic [7:0] idx;
        idx = addr[9:2];
        case (f3)
            LS_B_FN3: ref_mem[idx][8*addr[1:0] +: 8] = data[7:0];
            LS_H_FN3: ref_mem[idx][16*addr[1] +: 16] = data[15:0];
            default:  ref_mem[idx] = data;
        endcase
    endtask

    function automatic logic [31:0] expected_load(input fn3_t f3, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0] b;
        logic [15:0] h;
        w = ref_mem[addr[9:2]];
        case (addr[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = addr[1] ? w[31:16] : w[15:0];
        case (f3)
            LS_B_FN3: return {{24{b[7]}}, b};
            L_BU_FN3: return {24'h000000, b};
            LS_H_FN3: return {{16{h[15]}}, h};
            L_HU_FN3: return {16'h0000, h};
            default:  return w;
        endcase
    endfunction

    // Ends the run if the sequence stalls
    initial begin
        #((NUM_OPS + 50) * 40);
        $display("Timeout after %0d cycles, test sequence did not complete", NUM_OPS + 50);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed = 37289;
        rst = 1'b1;
        issue_valid = 1'b0;
        instruction = '0;
        rs1_data = '0;
        rs2_data = '0;
        id = '0;
        exc_pend = 1'b0;
        exp_unit = 1'b0;
        cycle_count = 0;
        error_count = 0;
        tag_count = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        fill_memory();
        test_word_rw();
        test_sub_word();
        test_partial_store();
        test_misaligned();
        test_back_to_back();
        test_non_ls();
        repeat (3) step(1'b0, '0, '0, '0, '0, 1'b0);

        if (exp_due.size() != 0) begin
            $display("%0d loads never wrote back", exp_due.size());
            error_count++;
        end
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/load_store_unit.sv ====
// Load/store unit top level
// Accepts one load or store per cycle when ready, writes stores into the
// local memory, tracks load attributes until the data returns and writes
// the aligned result back with its id. Misaligned accesses touch nothing
// and raise an exception one cycle after acceptance.

`timescale 1ns/1ns
`default_nettype none

module load_store_unit #(
    parameter int MEM_WORDS = 256,
    parameter int MEM_LATENCY = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  riscv_pkg::inst_t instruction,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  lsu_pkg::id_t id,
    output logic ready,
    output logic unit_needed,
    output logic wb_done,
    output lsu_pkg::id_t wb_id,
    output logic [31:0] wb_rd,
    output logic exc_valid,
    output riscv_pkg::exc_code_t exc_code,
    output logic [31:0] exc_tval,
    output lsu_pkg::id_t exc_id
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    logic is_load;
    logic is_store;
    logic misaligned;
    logic [31:0] address;
    logic [3:0] byte_en;
    logic [31:0] store_data;
    load_attr_t issue_attr;

    logic accept;
    logic mem_read;
    logic mem_write;
    logic mem_data_valid;
    logic [31:0] mem_read_data;

    load_attr_t head_attr;
    logic fifo_full;
    logic fifo_empty;

    ls_decode u_decode (
        .instruction (instruction),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id          (id),
        .unit_needed (unit_needed),
        .is_load     (is_load),
        .is_store    (is_store),
        .misaligned  (misaligned),
        .address     (address),
        .byte_en     (byte_en),
        .store_data  (store_data),
        .attr        (issue_attr)
    );

    //////////////////////////////////////////////////
    // Issue control
    assign accept = issue_valid & ready & unit_needed;
    assign mem_read = accept & is_load & ~misaligned;
    assign mem_write = accept & is_store & ~misaligned;

    // A returning load frees its slot in the same cycle
    assign ready = ~fifo_full | wb_done;

    local_mem_unit #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .read_req   (mem_read),
        .write_req  (mem_write),
        .address    (address),
        .byte_en    (byte_en),
        .write_data (store_data),
        .data_valid (mem_data_valid),
        .read_data  (mem_read_data)
    );

    load_attr_fifo #(
        .DEPTH (MEM_LATENCY)
    ) u_attr_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (mem_read),
        .pop      (wb_done),
        .data_in  (issue_attr),
        .data_out (head_attr),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

    load_align u_align (
        .word_data (mem_read_data),
        .attr      (head_attr),
        .result    (wb_rd)
    );

    //////////////////////////////////////////////////
    // Writeback and exceptions
    assign wb_done = mem_data_valid & ~fifo_empty;
    assign wb_id = head_attr.id;

    always_ff @(posedge clk) begin
        if (rst)
            exc_valid <= 1'b0;
        else
            exc_valid <= accept & misaligned;
    end

    always_ff @(posedge clk) begin
        if (accept && misaligned) begin
            exc_code <= is_load ? LOAD_ADDR_MISALIGNED : STORE_ADDR_MISALIGNED;
            exc_tval <= address;
            exc_id <= id;
        end
    end

endmodule

`default_nettype wire

// ==== source/load_align.sv ====
// Load data alignment
// Picks the addressed byte or halfword out of the returned memory word and
// sign- or zero-extends it to 32 bits; words pass through unchanged

`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  logic [31:0] word_data,
    input  lsu_pkg::load_attr_t attr,
    output logic [31:0] result
);
    import lsu_pkg::*;

    logic [7:0] byte_val;
    logic [15:0] half_val;
    logic byte_sign;
    logic half_sign;

    assign byte_val = word_data[8*attr.byte_addr +: 8];
    // Halfwords are aligned, so bit 1 of the address selects the half
    assign half_val = attr.byte_addr[1] ? word_data[31:16] : word_data[15:0];

    assign byte_sign = attr.is_signed & byte_val[7];
    assign half_sign = attr.is_signed & half_val[15];

    always_comb begin
        case (attr.size)
            SIZE_BYTE: result = {{24{byte_sign}}, byte_val};
            SIZE_HALF: result = {{16{half_sign}}, half_val};
            default:   result = word_data;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/load_attr_fifo.sv ====
// Attribute FIFO for loads in flight
// Circular buffer with an occupancy count. The head entry is always on
// data_out. Push and pop may happen together, also when the FIFO is full,
// so a depth equal to the memory latency sustains one load per cycle.

`timescale 1ns/1ns
`default_nettype none

module load_attr_fifo #(
    parameter int DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  lsu_pkg::load_attr_t data_in,
    output lsu_pkg::load_attr_t data_out,
    output logic full,
    output logic empty
);
    import lsu_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    load_attr_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign data_out = entries[rd_ptr];
    assign full = (count == COUNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== source/local_mem_unit.sv ====
// On-chip data memory for the load/store unit
// 32-bit words with per-byte write enables; writes complete at the request
// edge. Read data and its valid flag come out MEM_LATENCY cycles after the
// read edge, and a new read may start every cycle. Upper address bits wrap.

`timescale 1ns/1ns
`default_nettype none

module local_mem_unit #(
    parameter int MEM_WORDS = 256,
    parameter int MEM_LATENCY = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic read_req,
    input  logic write_req,
    input  logic [31:0] address,
    input  logic [3:0] byte_en,
    input  logic [31:0] write_data,
    output logic data_valid,
    output logic [31:0] read_data
);
    localparam int INDEX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [INDEX_W-1:0] word_index;
    logic [31:0] data_pipe [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] valid_pipe;

    assign word_index = address[INDEX_W+1:2];

    always_ff @(posedge clk) begin
        if (write_req) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b])
                    mem[word_index][8*b +: 8] <= write_data[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read pipeline
    always_ff @(posedge clk) begin
        if (read_req)
            data_pipe[0] <= mem[word_index];
        for (int i = 1; i < MEM_LATENCY; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= read_req;
            for (int i = 1; i < MEM_LATENCY; i++)
                valid_pipe[i] <= valid_pipe[i-1];
        end
    end

    assign data_valid = valid_pipe[MEM_LATENCY-1];
    assign read_data = data_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== source/ls_decode.sv ====
// Decode stage of the load/store unit
// Recognizes RV32I loads and stores, adds rs1 to the sign-extended offset,
// builds byte enables, places store data in its byte lanes and flags
// misaligned halfword and word accesses. Purely combinational.

`timescale 1ns/1ns
`default_nettype none

module ls_decode (
    input  riscv_pkg::inst_t instruction,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  lsu_pkg::id_t id,
    output logic unit_needed,
    output logic is_load,
    output logic is_store,
    output logic misaligned,
    output logic [31:0] address,
    output logic [3:0] byte_en,
    output logic [31:0] store_data,
    output lsu_pkg::load_attr_t attr
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    opcode_t opcode;
    fn3_t fn3;
    logic [11:0] offset;
    access_size_t size;

    assign opcode = instruction[6:0];
    assign fn3 = instruction[14:12];

    assign is_load = (opcode == LOAD_OPCODE) &&
        (fn3 inside {LS_B_FN3, LS_H_FN3, LS_W_FN3, L_BU_FN3, L_HU_FN3});
    assign is_store = (opcode == STORE_OPCODE) && (fn3 inside {LS_B_FN3, LS_H_FN3, LS_W_FN3});
    assign unit_needed = is_load | is_store;

    //////////////////////////////////////////////////
    // Effective address
    // S-type splits the immediate around rd
    assign offset = is_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];
    assign address = rs1_data + {{20{offset[11]}}, offset};

    assign size = access_size_t'(fn3[1:0]);

    assign misaligned = unit_needed &&
        (((size == SIZE_HALF) && address[0]) || ((size == SIZE_WORD) && (address[1:0] != 2'b00)));

    //////////////////////////////////////////////////
    // Store lanes
    always_comb begin
        case (size)
            SIZE_BYTE: byte_en = 4'b0001 << address[1:0];
            SIZE_HALF: byte_en = 4'b0011 << {address[1], 1'b0};
            default:   byte_en = 4'b1111;
        endcase
    end

    assign store_data = rs2_data << {address[1:0], 3'b000};

    // LBU and LHU have funct3[2] set
    assign attr = '{
        is_signed: ~fn3[2],
        size:      size,
        byte_addr: address[1:0],
        id:        id
    };

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
// Types internal to the load/store unit
// The issuer's instruction tag, the access size and the record that
// travels with each load until its data comes back from memory

`default_nettype none

package lsu_pkg;

    typedef logic [2:0] id_t;

    // Matches the low two bits of funct3
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    // What load_align needs to finish a load, plus its writeback tag
    typedef struct packed {
        logic is_signed;
        access_size_t size;
        logic [1:0] byte_addr;
        id_t id;
    } load_attr_t;

endpackage

`default_nettype wire

// ==== source/riscv_pkg.sv ====
// RISC-V encodings used by the load/store unit
// Major opcodes and funct3 values for the RV32I integer loads and stores,
// plus the exception causes raised for misaligned accesses
// Import inside a module body, or use scoped names in port lists

`default_nettype none

package riscv_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] fn3_t;
    typedef logic [4:0] exc_code_t;

    //////////////////////////////////////////////////
    // Major opcodes
    localparam opcode_t LOAD_OPCODE = 7'b0000011;
    localparam opcode_t STORE_OPCODE = 7'b0100011;

    //////////////////////////////////////////////////
    // funct3 for LB/SB, LH/SH, LW/SW and the unsigned loads
    localparam fn3_t LS_B_FN3 = 3'b000;
    localparam fn3_t LS_H_FN3 = 3'b001;
    localparam fn3_t LS_W_FN3 = 3'b010;
    localparam fn3_t L_BU_FN3 = 3'b100;
    localparam fn3_t L_HU_FN3 = 3'b101;

    //////////////////////////////////////////////////
    // Exception causes (mcause encoding)
    localparam exc_code_t LOAD_ADDR_MISALIGNED = 5'd4;
    localparam exc_code_t STORE_ADDR_MISALIGNED = 5'd6;

endpackage

`default_nettype wire
